/* Makefile */
SRCS := $(wildcard logic/*.sv) $(wildcard dv/*.sv)

.PHONY: run clean

run: obj_dir/Vfetch_stage_tb
	./obj_dir/Vfetch_stage_tb | tee sim.log
	grep -q "^Done: no errors$$" sim.log

obj_dir/Vfetch_stage_tb: sim.f $(SRCS)
	verilator --binary --timing --assert --top-module fetch_stage_tb -f sim.f

clean:
	rm -rf obj_dir sim.log

/* dv/ahb_rom_model.sv */
module ahb_rom_model #(
    parameter int               SEED     = 32'h2189,        // Start value of the wait-state stream
    parameter fetch_pkg::word_t DATA_KEY = 32'hA5A5_0000    // Word = address XOR key
) (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  fetch_pkg::ahb_req_t ahb_req_i,                  // Request from the fetch stage
    input  logic [1:0]          wait_max_i,                 // Most wait states per transfer
    input  fetch_pkg::addr_t    err_addr_i,                 // Address answered with hresp
    output fetch_pkg::ahb_rsp_t ahb_rsp_o
);
    timeunit 1ns;
    timeprecision 1ps;

    int                  seed;
    fetch_pkg::ahb_req_t req_s;         // Request as seen mid-cycle
    logic                dp_valid;      // Data phase in progress
    fetch_pkg::addr_t    dp_addr;       // Address of that data phase
    int                  wait_cnt;      // Wait states still to insert

    initial begin
        seed      = SEED;
        req_s     = '0;
        dp_valid  = 1'b0;
        dp_addr   = '0;
        wait_cnt  = 0;
        ahb_rsp_o = '{hrdata: '0, hready: 1'b1, hresp: 1'b0};   // Idle bus is ready
    end

    // The request only changes at the clock edge, so mid-cycle is safe
    always @(negedge clk_i) begin
        req_s = ahb_req_i;
    end

    always @(posedge clk_i) begin
        if (!arst_n_i) begin
            dp_valid = 1'b0;
            wait_cnt = 0;
        end else if (ahb_rsp_o.hready) begin
            // Previous data phase done, address phase accepted if NONSEQ
            dp_valid = req_s.htrans == fetch_pkg::NONSEQ;
            dp_addr  = req_s.haddr;
            if (dp_valid) begin
                wait_cnt = int'({$random(seed)} % (32'(wait_max_i) + 32'd1));
            end else begin
                wait_cnt = 0;
            end
        end else begin
            wait_cnt = wait_cnt - 1;                // One wait state spent
        end

        #1;                                         // Response settles shortly after the edge
        ahb_rsp_o.hready = !dp_valid || (wait_cnt == 0);
        ahb_rsp_o.hrdata = dp_valid ? (dp_addr ^ DATA_KEY) : '0;
        // Error shows up together with the final hready only
        ahb_rsp_o.hresp  = dp_valid && (wait_cnt == 0) && (dp_addr == err_addr_i);
    end

endmodule

/* dv/fetch_stage_tb.sv */
module fetch_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int               BUF_DEPTH  = 4;
    localparam int               CLK_PERIOD = 40;
    localparam int               SEED       = 32'h2189;
    localparam fetch_pkg::word_t DATA_KEY   = 32'hA5A5_0000;    // ROM contents key
    localparam fetch_pkg::addr_t NO_ERR     = 32'hFFFF_FFF0;    // Never fetched

    typedef enum logic [1:0] {
        NO_FLUSH,
        FLUSH_IN_WAIT,                  // Flush while a NONSEQ waits on hready
        FLUSH_ON_READY                  // Flush while the bus takes an address
    } flush_kind_e;

    // One row of the stimulus table
    typedef struct packed {
        flush_kind_e      flush;
        fetch_pkg::addr_t redirect;
        int               words;        // Entries decode takes in this row
        int               low_pct;      // Chance of ready_i low, in percent
        int               wait_max;     // Bus wait states 0 to wait_max
        fetch_pkg::addr_t err_addr;
    } row_t;

    localparam int   NUM_ROWS = 7;
    localparam row_t ROWS [NUM_ROWS] = '{
        '{NO_FLUSH,       32'h0000_0000, 12,  0, 0, NO_ERR},
        '{NO_FLUSH,       32'h0000_0000, 24, 40, 3, 32'h0000_0160},
        '{FLUSH_IN_WAIT,  32'h0000_2000, 16, 30, 3, 32'h0000_2020},
        '{FLUSH_ON_READY, 32'h0000_3000, 16, 50, 2, 32'h0000_3010},
        '{NO_FLUSH,       32'h0000_0000, 20, 70, 1, NO_ERR},
        '{FLUSH_IN_WAIT,  32'h0000_0400, 12, 20, 3, 32'h0000_0404},
        '{FLUSH_ON_READY, 32'h0000_5000, 10,  0, 0, 32'h0000_5008}
    };

    logic                    clk = 1'b0;
    logic                    arst_n;
    logic                    flush;
    fetch_pkg::addr_t        redirect;
    fetch_pkg::ahb_rsp_t     ahb_rsp;
    fetch_pkg::ahb_req_t     ahb_req;
    logic                    valid;
    fetch_pkg::fetch_entry_t entry;
    logic                    ready;
    logic [1:0]              wait_max;  // ROM model setup
    fetch_pkg::addr_t        err_addr;

    int                      seed;
    fetch_pkg::addr_t        model_addr;    // Address decode expects next
    logic                    held_wait;     // Last cycle had a NONSEQ in a wait state
    fetch_pkg::ahb_req_t     held_req;

    always #(CLK_PERIOD / 2) clk = ~clk;

    fetch_stage #(
        .BUF_DEPTH  (BUF_DEPTH)
    ) UUT (
        .s_clk_i    (clk),
        .arst_n_i   (arst_n),
        .flush_i    (flush),
        .redirect_i (redirect),
        .ahb_rsp_i  (ahb_rsp),
        .ahb_req_o  (ahb_req),
        .valid_o    (valid),
        .entry_o    (entry),
        .ready_i    (ready)
    );

    ahb_rom_model #(
        .SEED       (SEED),
        .DATA_KEY   (DATA_KEY)
    ) u_rom (
        .clk_i      (clk),
        .arst_n_i   (arst_n),
        .ahb_req_i  (ahb_req),
        .wait_max_i (wait_max),
        .err_addr_i (err_addr),
        .ahb_rsp_o  (ahb_rsp)
    );

    task automatic stop_with_failure();
        $display("Done: errors found");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_entry(input fetch_pkg::fetch_entry_t got,
                               input fetch_pkg::fetch_entry_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: entry_o got addr %h instr %h status %0d, expected %h %h %0d",
                     $time, got.addr, got.instr, got.status, exp.addr, exp.instr, exp.status);
            stop_with_failure();
        end
    endtask

    task automatic check_bus_req(input fetch_pkg::ahb_req_t got, input fetch_pkg::ahb_req_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: ahb_req_o got haddr %h htrans %0d, expected haddr %h htrans %0d",
                     $time, got.haddr, got.htrans, exp.haddr, exp.htrans);
            stop_with_failure();
        end
    endtask

    task automatic check_valid(input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail at %0t: valid_o got %b expected %b", $time, got, exp);
            stop_with_failure();
        end
    endtask

    // Waits for the chosen bus situation, then pulses flush with the redirect
    task automatic apply_flush(input row_t row);
        logic hit;
        hit = 1'b0;
        while (!hit) begin
            @(posedge clk);
            #2;
            if (row.flush == FLUSH_IN_WAIT) begin
                hit = (ahb_req.htrans == fetch_pkg::NONSEQ) && !ahb_rsp.hready;
            end else begin
                hit = (ahb_req.htrans == fetch_pkg::NONSEQ) && ahb_rsp.hready;
            end
            flush    = hit;
            redirect = hit ? row.redirect : '0;
            ready    = !hit;                // Drain old words so the bus keeps busy
        end
        @(posedge clk);
        #2;
        flush = 1'b0;
        ready = 1'b0;
        model_addr = row.redirect;
    endtask

    // Decode held off long enough for the space check to stop the bus
    task automatic stall_decode();
        logic idle_seen;
        idle_seen = 1'b0;
        repeat (BUF_DEPTH + 2) begin
            @(posedge clk);
            #2;
            ready = 1'b0;
            if (ahb_req.htrans == fetch_pkg::IDLE) begin
                idle_seen = 1'b1;
            end
        end
        if (!idle_seen) begin
            $display("Fail at %0t: bus never went idle while decode was stalled", $time);
            stop_with_failure();
        end
    endtask

    task automatic consume_words(input row_t row);
        int                      taken;
        fetch_pkg::fetch_entry_t exp;
        taken = 0;
        while (taken < row.words) begin
            @(posedge clk);
            #2;
            ready = ({$random(seed)} % 32'd100) >= 32'(row.low_pct);
            if (valid && ready) begin               // Handshake completes at the next edge
                exp.addr   = model_addr;
                exp.instr  = model_addr ^ DATA_KEY;
                exp.status = (model_addr == row.err_addr) ? fetch_pkg::FETCH_BUS_ERROR
                                                          : fetch_pkg::FETCH_OK;
                check_entry(entry, exp);
                model_addr = model_addr + 32'd4;
                taken++;
            end
        end
    endtask

    // AHB rule: a NONSEQ stuck in a wait state keeps address and type
    always @(negedge clk) begin
        if (arst_n) begin
            if (held_wait) begin
                check_bus_req(ahb_req, held_req);
            end
            held_wait = (ahb_req.htrans == fetch_pkg::NONSEQ) && !ahb_rsp.hready;
            held_req  = ahb_req;
        end else begin
            held_wait = 1'b0;
        end
    end

    initial begin : watchdog
        int total_words;
        total_words = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            total_words += ROWS[i].words;
        end
        #(total_words * 20 * CLK_PERIOD);
        $display("Timeout at %0t: the fetch stage stopped delivering instructions", $time);
        stop_with_failure();
    end

    initial begin : stimulus
        fetch_pkg::ahb_req_t want;
        $timeformat(-9, 0, " ns", 0);
        seed      = SEED;
        arst_n    = 1'b0;
        flush     = 1'b0;
        redirect  = '0;
        ready     = 1'b0;
        wait_max  = 2'd0;
        err_addr  = NO_ERR;
        held_wait = 1'b0;
        held_req  = '0;

        repeat (2) @(posedge clk);
        #2;
        want.haddr  = fetch_pkg::RESET_ADDR;
        want.htrans = fetch_pkg::IDLE;
        check_bus_req(ahb_req, want);           // Quiet bus and empty IFB in reset
        check_valid(valid, 1'b0);
        arst_n = 1'b1;

        @(posedge clk);
        #2;
        want.htrans = fetch_pkg::NONSEQ;        // First fetch right after reset
        check_bus_req(ahb_req, want);
        model_addr = fetch_pkg::RESET_ADDR;

        for (int r = 0; r < NUM_ROWS; r++) begin
            wait_max = 2'(ROWS[r].wait_max);
            err_addr = ROWS[r].err_addr;
            if (ROWS[r].flush != NO_FLUSH) begin
                apply_flush(ROWS[r]);
            end
            if (ROWS[r].wait_max == 0) begin
                stall_decode();                 // Fill timing is fixed without wait states
            end
            consume_words(ROWS[r]);
        end

        @(posedge clk);
        #2;
        ready = 1'b0;
        $display("Done: no errors");
        $finish;
    end

endmodule

/* logic/fetch_buffer.sv */
module fetch_buffer #(
    parameter int BUF_DEPTH = 4
) (
    input  logic                                 s_clk_i,
    input  logic                                 arst_n_i,
    input  logic                                 flush_i,       // Drop all entries
    input  logic                                 push_i,        // Write one entry
    input  fetch_pkg::fetch_entry_t              push_entry_i,
    input  logic                                 pop_i,         // Decode ready
    output logic                                 valid_o,       // Head entry present
    output fetch_pkg::fetch_entry_t              entry_o,       // Head entry
    output logic [$clog2(BUF_DEPTH + 1)-1:0]     occupied_o     // Number of held entries
);

    localparam int PTR_W = $clog2(BUF_DEPTH);
    localparam int CNT_W = $clog2(BUF_DEPTH + 1);

    fetch_pkg::fetch_entry_t mem_q [BUF_DEPTH];   // Entry storage, no reset

    logic [PTR_W-1:0] wr_ptr_q;                 // Next slot to write
    logic [PTR_W-1:0] rd_ptr_q;                 // Oldest entry
    logic [CNT_W-1:0] count_q;
    logic             pop;                      // Pop of a present entry

    // Circular increment, depth need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (ptr == PTR_W'(BUF_DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + PTR_W'(1);
        end
        return nxt;
    endfunction

    assign valid_o    = count_q != '0;
    assign pop        = pop_i & valid_o;        // Ready alone does not pop an empty IFB
    assign entry_o    = mem_q[rd_ptr_q];
    assign occupied_o = count_q;

    // Pointers and count
    always_ff @(posedge s_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;                     // Everything buffered is from the old flow
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            case ({push_i, pop})
                2'b10:   count_q <= count_q + CNT_W'(1);
                2'b01:   count_q <= count_q - CNT_W'(1);
                default: count_q <= count_q;    // Both or neither
            endcase
        end
    end

    // Storage write
    always_ff @(posedge s_clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= push_entry_i;
        end
    end

    // The controller reserves a slot before every fetch
    a_no_push_full: assert property (@(posedge s_clk_i) disable iff (!arst_n_i)
        push_i |-> (count_q < CNT_W'(BUF_DEPTH)))
        else $error("IFB overflow, fetch issued without free slot");

endmodule

/* logic/fetch_phase_ctrl.sv */
module fetch_phase_ctrl #(
    parameter int BUF_DEPTH = 4
) (
    input  logic                                 s_clk_i,
    input  logic                                 arst_n_i,
    input  logic                                 flush_i,       // Redirect request
    input  fetch_pkg::addr_t                     redirect_i,    // Redirect target
    input  fetch_pkg::ahb_rsp_t                  ahb_rsp_i,
    input  logic [$clog2(BUF_DEPTH + 1)-1:0]     occupied_i,    // IFB fill level
    output fetch_pkg::ahb_req_t                  ahb_req_o,
    output logic                                 push_o,        // Store word into IFB
    output fetch_pkg::fetch_entry_t              push_entry_o
);

    localparam int CNT_W = $clog2(BUF_DEPTH + 1);

    // FE0 holds the address phase, FE1 the data phase
    fetch_pkg::addr_t fe0_add_q, fe0_add_d;
    logic             fe0_utd_q, fe0_utd_d;     // Address phase belongs to the current flow
    fetch_pkg::addr_t fe1_add_q, fe1_add_d;
    logic             fe1_utd_q, fe1_utd_d;     // Returned data will be needed
    logic             fe1_park_q, fe1_park_d;   // FE1 holds a redirect waiting for FE0

    logic             hready;
    logic             fe0_hold;                 // Address must stay on the bus
    logic [CNT_W-1:0] free_cnt;                 // Empty IFB entries
    logic [1:0]       busy_cnt;                 // Words already in flight
    logic             ifb_available;            // Room for one more fetch

    assign hready   = ahb_rsp_i.hready;
    assign fe0_hold = ~hready & fe0_utd_q;      // Waiting NONSEQ may not change

    // A new fetch needs a slot beyond every phase still in flight
    assign free_cnt      = CNT_W'(BUF_DEPTH) - occupied_i;
    assign busy_cnt      = {1'b0, fe0_utd_q} + {1'b0, fe1_utd_q};
    assign ifb_available = free_cnt > CNT_W'(busy_cnt);

    // Bus request straight from FE0
    assign ahb_req_o.haddr  = fe0_add_q;
    assign ahb_req_o.htrans = fe0_utd_q ? fetch_pkg::NONSEQ : fetch_pkg::IDLE;

    // Data phase completes into the IFB, never in the flush cycle
    assign push_o              = fe1_utd_q & hready & ~flush_i;
    assign push_entry_o.instr  = ahb_rsp_i.hrdata;
    assign push_entry_o.status = ahb_rsp_i.hresp ? fetch_pkg::FETCH_BUS_ERROR
                                                 : fetch_pkg::FETCH_OK;
    assign push_entry_o.addr   = fe1_add_q;

    always_comb begin : fe0_update
        fe0_add_d = fe0_add_q;
        fe0_utd_d = fe0_utd_q;
        if (fe0_hold) begin
            // Stalled address phase keeps its address and type
        end else if (flush_i) begin
            fe0_add_d = {redirect_i[31:2], 2'b00};  // IFB is emptied, no space check needed
            fe0_utd_d = 1'b1;
        end else if (fe1_park_q) begin
            fe0_add_d = fe1_add_q;                  // Parked redirect moves to the bus
            fe0_utd_d = 1'b1;
        end else if (fe0_utd_q) begin
            fe0_add_d = fe0_add_q + 32'd4;          // Accepted, go to the next word
            fe0_utd_d = ifb_available;
        end else begin
            fe0_utd_d = ifb_available;              // Waiting for IFB room
        end
    end

    always_comb begin : fe1_update
        fe1_add_d  = fe1_add_q;
        fe1_utd_d  = fe1_utd_q;
        fe1_park_d = fe1_park_q;
        if (flush_i & fe0_hold) begin
            // FE0 is locked on the bus, keep the redirect here meanwhile
            fe1_add_d  = {redirect_i[31:2], 2'b00};
            fe1_utd_d  = 1'b0;
            fe1_park_d = 1'b1;
        end else if (flush_i | (hready & fe1_park_q)) begin
            fe1_utd_d  = 1'b0;                      // Phase moving in is stale
            fe1_park_d = 1'b0;
        end else if (hready) begin
            fe1_add_d  = fe0_add_q;                 // Address phase turns into data phase
            fe1_utd_d  = fe0_utd_q;
            fe1_park_d = 1'b0;
        end
    end

    always_ff @(posedge s_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fe0_add_q  <= fetch_pkg::RESET_ADDR;
            fe0_utd_q  <= 1'b0;
            fe1_utd_q  <= 1'b0;
            fe1_park_q <= 1'b0;
        end else begin
            fe0_add_q  <= fe0_add_d;
            fe0_utd_q  <= fe0_utd_d;
            fe1_utd_q  <= fe1_utd_d;
            fe1_park_q <= fe1_park_d;
        end
    end

    always_ff @(posedge s_clk_i) begin
        fe1_add_q <= fe1_add_d;                     // Qualified by fe1_utd_q and fe1_park_q
    end

    // AHB rule, a waiting address phase is frozen until hready
    a_req_stable: assert property (@(posedge s_clk_i) disable iff (!arst_n_i)
        (ahb_req_o.htrans == fetch_pkg::NONSEQ) && !hready |=> $stable(ahb_req_o))
        else $error("fetch request changed during a wait state");

    // Buffered words plus words in flight never exceed the IFB
    a_room_kept: assert property (@(posedge s_clk_i) disable iff (!arst_n_i)
        (32'(occupied_i) + 32'(busy_cnt)) <= 32'(BUF_DEPTH))
        else $error("more fetches in flight than free IFB entries");

endmodule

/* logic/fetch_pkg.sv */
package fetch_pkg;

    // Basic bus quantities
    typedef logic [31:0] addr_t;    // Byte address
    typedef logic [31:0] word_t;    // Instruction word

    // AHB transfer type, only the two kinds a fetch unit issues
    typedef enum logic [1:0] {
        IDLE   = 2'b00,             // No transfer
        NONSEQ = 2'b10              // Single word read
    } htrans_e;

    // Request side of the instruction bus, driven by the fetch stage
    typedef struct packed {
        addr_t   haddr;             // Word aligned fetch address
        htrans_e htrans;            // Transfer type
    } ahb_req_t;

    // Response side of the instruction bus
    typedef struct packed {
        word_t hrdata;              // Read data of the current data phase
        logic  hready;              // Data phase finished
        logic  hresp;               // Error response, sampled with hready
    } ahb_rsp_t;

    // Status attached to every buffered instruction
    typedef enum logic {
        FETCH_OK        = 1'b0,
        FETCH_BUS_ERROR = 1'b1      // Bus answered with hresp
    } fetch_status_e;

    // One IFB entry, also the word handed to decode
    typedef struct packed {
        word_t         instr;
        fetch_status_e status;
        addr_t         addr;        // Address the word came from
    } fetch_entry_t;

    // First fetch address after reset
    localparam addr_t RESET_ADDR = 32'h0000_0100;

endpackage

/* logic/fetch_stage.sv */
module fetch_stage #(
    parameter int BUF_DEPTH = 4                     // IFB entries, at least 3
) (
    input  logic                    s_clk_i,        // Core clock
    input  logic                    arst_n_i,       // Async reset, active low

    input  logic                    flush_i,        // Redirect pulse from a later stage
    input  fetch_pkg::addr_t        redirect_i,     // New fetch address on flush

    input  fetch_pkg::ahb_rsp_t     ahb_rsp_i,      // Instruction bus response
    output fetch_pkg::ahb_req_t     ahb_req_o,      // Instruction bus request

    output logic                    valid_o,        // Entry available for decode
    output fetch_pkg::fetch_entry_t entry_o,        // Oldest buffered instruction
    input  logic                    ready_i         // Decode takes the entry
);

    localparam int CNT_W = $clog2(BUF_DEPTH + 1);

    /*  The stage is split in two parts:
        the phase controller owns FE0 (address phase) and FE1 (data phase),
        the IFB decouples bus timing from decode back-pressure.
        The occupancy count closes the loop so that no fetch is started
        unless its word is sure to find a free IFB slot. */

    logic                    ifb_push;              // Completed data phase to store
    fetch_pkg::fetch_entry_t ifb_push_entry;        // Word, status and address
    logic [CNT_W-1:0]        ifb_occupied;          // Entries held in the IFB

    // Address and data phase sequencing
    fetch_phase_ctrl #(
        .BUF_DEPTH    (BUF_DEPTH)
    ) u_phase_ctrl (
        .s_clk_i      (s_clk_i),
        .arst_n_i     (arst_n_i),
        .flush_i      (flush_i),
        .redirect_i   (redirect_i),
        .ahb_rsp_i    (ahb_rsp_i),
        .occupied_i   (ifb_occupied),
        .ahb_req_o    (ahb_req_o),
        .push_o       (ifb_push),
        .push_entry_o (ifb_push_entry)
    );

    // Instruction fetch buffer towards decode
    fetch_buffer #(
        .BUF_DEPTH    (BUF_DEPTH)
    ) u_ifb (
        .s_clk_i      (s_clk_i),
        .arst_n_i     (arst_n_i),
        .flush_i      (flush_i),                    // Stale words are dropped on redirect
        .push_i       (ifb_push),
        .push_entry_i (ifb_push_entry),
        .pop_i        (ready_i),                    // Qualified with valid inside the IFB
        .valid_o      (valid_o),
        .entry_o      (entry_o),
        .occupied_o   (ifb_occupied)
    );

endmodule

/* sim.f */
logic/fetch_pkg.sv
logic/fetch_buffer.sv
logic/fetch_phase_ctrl.sv
logic/fetch_stage.sv
dv/ahb_rom_model.sv
dv/fetch_stage_tb.sv
